//--- ahbApbSys.f
+incdir+logic
logic/ahbApbSysPkg.sv
logic/apbIf.sv
logic/ahbApbBridge.sv
logic/apbSlotMux.sv
logic/apbTimer.sv
logic/apbPwm.sv
logic/ahbApbSys.sv
sim/ahbApbSysTb.sv

//--- logic/ahbApbBridge.sv
`timescale 1ns/1ns

module ahbApbBridge (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbApbSysPkg::addrT hAddr_i,
    input  logic [1:0]         hTrans_i,
    input  logic               hWrite_i,
    input  logic               hSel_i,
    input  logic               hReady_i,
    input  ahbApbSysPkg::dataT hWdata_i,
    output ahbApbSysPkg::dataT hRdata_o,
    output logic               hReadyOut_o,
    apbIf.requester            apb
);

    ahbApbSysPkg::bridgeStateT stateQ;
    ahbApbSysPkg::bridgeStateT stateD;
    ahbApbSysPkg::addrT        addrQ;
    ahbApbSysPkg::dataT        wdataQ;
    ahbApbSysPkg::dataT        rdataQ;
    logic                      writeQ;
    logic                      start;

    // NONSEQ or SEQ transfer in an address phase
    assign start = hSel_i && hTrans_i[1] && hReady_i &&
                   (stateQ == ahbApbSysPkg::IDLE);

    always_comb begin
        stateD = stateQ;
        case (stateQ)
            ahbApbSysPkg::IDLE: begin
                if (start) begin
                    stateD = ahbApbSysPkg::SETUP;
                end
            end
            ahbApbSysPkg::SETUP: begin
                stateD = ahbApbSysPkg::ACCESS;
            end
            ahbApbSysPkg::ACCESS: begin
                // Slave back-pressure keeps us here
                if (apb.pready) begin
                    stateD = ahbApbSysPkg::IDLE;
                end
            end
            default: begin
                stateD = ahbApbSysPkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            stateQ <= ahbApbSysPkg::IDLE;
            writeQ <= 1'b0;
            rdataQ <= '0;
        end else begin
            stateQ <= stateD;
            if (start) begin
                writeQ <= hWrite_i;
            end
            if ((stateQ == ahbApbSysPkg::ACCESS) && apb.pready && !writeQ) begin
                rdataQ <= apb.prdata;
            end
        end
    end

    // Address from the address phase, write data from the SETUP cycle
    always_ff @(posedge HCLK) begin
        if (start) begin
            addrQ <= hAddr_i;
        end
        if (stateQ == ahbApbSysPkg::SETUP) begin
            wdataQ <= hWdata_i;
        end
    end

    assign apb.psel    = (stateQ != ahbApbSysPkg::IDLE);
    assign apb.penable = (stateQ == ahbApbSysPkg::ACCESS);
    assign apb.paddr   = addrQ;
    assign apb.pwrite  = writeQ;
    // AHB write data is live during SETUP and is held in wdataQ for ACCESS
    assign apb.pwdata  = (stateQ == ahbApbSysPkg::SETUP) ? hWdata_i : wdataQ;

    assign hReadyOut_o = (stateQ == ahbApbSysPkg::IDLE);
    assign hRdata_o    = rdataQ;

endmodule

//--- logic/ahbApbSys.sv
`timescale 1ns/1ns

module ahbApbSys (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbApbSysPkg::addrT hAddr_i,
    input  logic [1:0]         hTrans_i,
    input  logic               hWrite_i,
    input  ahbApbSysPkg::dataT hWdata_i,
    input  logic               hSel_i,
    input  logic               hReady_i,
    output ahbApbSysPkg::dataT hRdata_o,
    output logic               hReadyOut_o,
    output logic [1:0]         irq_o,
    output logic [1:0]         pwm_o
);

    apbIf busMain ();
    apbIf slot0 ();
    apbIf slot1 ();
    apbIf slot2 ();
    apbIf slot3 ();

    ahbApbBridge bridge0 (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hAddr_i     (hAddr_i),
        .hTrans_i    (hTrans_i),
        .hWrite_i    (hWrite_i),
        .hSel_i      (hSel_i),
        .hReady_i    (hReady_i),
        .hWdata_i    (hWdata_i),
        .hRdata_o    (hRdata_o),
        .hReadyOut_o (hReadyOut_o),
        .apb         (busMain.requester)
    );

    apbSlotMux mux0 (
        .up    (busMain.completer),
        .slot0 (slot0.requester),
        .slot1 (slot1.requester),
        .slot2 (slot2.requester),
        .slot3 (slot3.requester)
    );

    // Slots 0 and 1
    apbTimer tmr0 (.HCLK(HCLK), .HRESETn(HRESETn), .apb(slot0.completer), .irq_o(irq_o[0]));
    apbTimer tmr1 (.HCLK(HCLK), .HRESETn(HRESETn), .apb(slot1.completer), .irq_o(irq_o[1]));

    // Slots 2 and 3
    apbPwm pwm0 (.HCLK(HCLK), .HRESETn(HRESETn), .apb(slot2.completer), .pwm_o(pwm_o[0]));
    apbPwm pwm1 (.HCLK(HCLK), .HRESETn(HRESETn), .apb(slot3.completer), .pwm_o(pwm_o[1]));

endmodule

//--- logic/ahbApbSysPkg.sv
`include "ahbApbSys_consts.svh"

package ahbApbSysPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [`DATA_WIDTH-1:0] dataT;
    typedef logic [`DATA_WIDTH-1:0] countT;
    typedef logic [`SLOT_MSB-`SLOT_LSB:0] slotT;
    typedef logic [`REG_MSB-`REG_LSB:0] regIdxT;

    // One APB setup/access pair per AHB transfer
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } bridgeStateT;

endpackage

//--- logic/ahbApbSys_consts.svh
`ifndef AHB_APB_SYS_CONSTS_SVH
`define AHB_APB_SYS_CONSTS_SVH

`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// Slot decode on the APB address
`define SLOT_MSB   23
`define SLOT_LSB   20
`define SLOT_COUNT 16
`define SLOT_TMR0  4'd0
`define SLOT_TMR1  4'd1
`define SLOT_PWM0  4'd2
`define SLOT_PWM1  4'd3

// Word index inside a slot
`define REG_MSB 4
`define REG_LSB 2

`define TMR_COUNT  3'd0
`define TMR_PRE    3'd1
`define TMR_CMP    3'd2
`define TMR_OVF    3'd3
`define TMR_EN     3'd4

`define PWM_PRE    3'd0
`define PWM_PERIOD 3'd1
`define PWM_DUTY   3'd2
`define PWM_EN     3'd3

`endif

//--- logic/apbIf.sv
`timescale 1ns/1ns

interface apbIf;

    logic               psel;
    logic               penable;
    ahbApbSysPkg::addrT paddr;
    logic               pwrite;
    ahbApbSysPkg::dataT pwdata;
    ahbApbSysPkg::dataT prdata;
    logic               pready;

    modport requester (
        output psel,
        output penable,
        output paddr,
        output pwrite,
        output pwdata,
        input  prdata,
        input  pready
    );

    modport completer (
        input  psel,
        input  penable,
        input  paddr,
        input  pwrite,
        input  pwdata,
        output prdata,
        output pready
    );

endinterface

//--- logic/apbPwm.sv
`timescale 1ns/1ns
`include "ahbApbSys_consts.svh"

module apbPwm (
    input  logic    HCLK,
    input  logic    HRESETn,
    apbIf.completer apb,
    output logic    pwm_o
);

    ahbApbSysPkg::countT  preQ;
    ahbApbSysPkg::countT  periodQ;
    ahbApbSysPkg::countT  dutyQ;
    ahbApbSysPkg::countT  preCntQ;
    ahbApbSysPkg::countT  cntQ;
    ahbApbSysPkg::regIdxT regIdx;
    logic                 enQ;
    logic                 wrEn;
    logic                 tick;

    assign regIdx = apb.paddr[`REG_MSB:`REG_LSB];
    assign wrEn   = apb.psel && apb.penable && apb.pwrite;
    assign tick   = enQ && (preCntQ == preQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preQ    <= '0;
            periodQ <= '0;
            dutyQ   <= '0;
            enQ     <= 1'b0;
        end else if (wrEn) begin
            case (regIdx)
                `PWM_PRE:    preQ    <= apb.pwdata;
                `PWM_PERIOD: periodQ <= apb.pwdata;
                `PWM_DUTY:   dutyQ   <= apb.pwdata;
                `PWM_EN:     enQ     <= apb.pwdata[0];
                default: ;
            endcase
        end
    end

    // Period counter runs 0..PERIOD with one step per prescaler tick
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCntQ <= '0;
            cntQ    <= '0;
        end else if (!enQ) begin
            preCntQ <= '0;
            cntQ    <= '0;
        end else if (tick) begin
            preCntQ <= '0;
            cntQ    <= (cntQ == periodQ) ? '0 : cntQ + 1'b1;
        end else begin
            preCntQ <= preCntQ + 1'b1;
        end
    end

    always_comb begin
        case (regIdx)
            `PWM_PRE:    apb.prdata = preQ;
            `PWM_PERIOD: apb.prdata = periodQ;
            `PWM_DUTY:   apb.prdata = dutyQ;
            `PWM_EN:     apb.prdata = ahbApbSysPkg::dataT'(enQ);
            default:     apb.prdata = '0;
        endcase
    end

    assign apb.pready = 1'b1;
    assign pwm_o      = enQ && (cntQ < dutyQ);

endmodule

//--- logic/apbSlotMux.sv
`timescale 1ns/1ns
`include "ahbApbSys_consts.svh"

module apbSlotMux (
    apbIf.completer up,
    apbIf.requester slot0,
    apbIf.requester slot1,
    apbIf.requester slot2,
    apbIf.requester slot3
);

    ahbApbSysPkg::slotT slot;

    assign slot = up.paddr[`SLOT_MSB:`SLOT_LSB];

    // Shared request lines
    assign slot0.penable = up.penable;
    assign slot0.paddr   = up.paddr;
    assign slot0.pwrite  = up.pwrite;
    assign slot0.pwdata  = up.pwdata;
    assign slot1.penable = up.penable;
    assign slot1.paddr   = up.paddr;
    assign slot1.pwrite  = up.pwrite;
    assign slot1.pwdata  = up.pwdata;
    assign slot2.penable = up.penable;
    assign slot2.paddr   = up.paddr;
    assign slot2.pwrite  = up.pwrite;
    assign slot2.pwdata  = up.pwdata;
    assign slot3.penable = up.penable;
    assign slot3.paddr   = up.paddr;
    assign slot3.pwrite  = up.pwrite;
    assign slot3.pwdata  = up.pwdata;

    assign slot0.psel = up.psel && (slot == `SLOT_TMR0);
    assign slot1.psel = up.psel && (slot == `SLOT_TMR1);
    assign slot2.psel = up.psel && (slot == `SLOT_PWM0);
    assign slot3.psel = up.psel && (slot == `SLOT_PWM1);

    // Empty slots read as zero and never stall
    always_comb begin
        up.prdata = '0;
        up.pready = 1'b1;
        case (slot)
            `SLOT_TMR0: begin
                up.prdata = slot0.prdata;
                up.pready = slot0.pready;
            end
            `SLOT_TMR1: begin
                up.prdata = slot1.prdata;
                up.pready = slot1.pready;
            end
            `SLOT_PWM0: begin
                up.prdata = slot2.prdata;
                up.pready = slot2.pready;
            end
            `SLOT_PWM1: begin
                up.prdata = slot3.prdata;
                up.pready = slot3.pready;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/apbTimer.sv
`timescale 1ns/1ns
`include "ahbApbSys_consts.svh"

module apbTimer (
    input  logic    HCLK,
    input  logic    HRESETn,
    apbIf.completer apb,
    output logic    irq_o
);

    ahbApbSysPkg::countT  countQ;
    ahbApbSysPkg::countT  preQ;
    ahbApbSysPkg::countT  cmpQ;
    ahbApbSysPkg::countT  preCntQ;
    ahbApbSysPkg::regIdxT regIdx;
    logic                 enQ;
    logic                 ovfQ;
    logic                 wrEn;
    logic                 tick;
    logic                 wrap;

    assign regIdx = apb.paddr[`REG_MSB:`REG_LSB];
    assign wrEn   = apb.psel && apb.penable && apb.pwrite;
    assign tick   = enQ && (preCntQ == preQ);
    assign wrap   = tick && (countQ == cmpQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preQ <= '0;
            cmpQ <= '0;
            enQ  <= 1'b0;
        end else if (wrEn) begin
            case (regIdx)
                `TMR_PRE: preQ <= apb.pwdata;
                `TMR_CMP: cmpQ <= apb.pwdata;
                `TMR_EN:  enQ  <= apb.pwdata[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCntQ <= '0;
            countQ  <= '0;
            ovfQ    <= 1'b0;
        end else begin
            if (!enQ) begin
                preCntQ <= '0;
                countQ  <= '0;
            end else if (tick) begin
                preCntQ <= '0;
                countQ  <= wrap ? '0 : countQ + 1'b1;
            end else begin
                preCntQ <= preCntQ + 1'b1;
            end
            // A new overflow beats a clear in the same cycle
            if (wrEn && (regIdx == `TMR_OVF) && apb.pwdata[0]) begin
                ovfQ <= 1'b0;
            end
            if (wrap) begin
                ovfQ <= 1'b1;
            end
        end
    end

    always_comb begin
        case (regIdx)
            `TMR_COUNT: apb.prdata = countQ;
            `TMR_PRE:   apb.prdata = preQ;
            `TMR_CMP:   apb.prdata = cmpQ;
            `TMR_OVF:   apb.prdata = ahbApbSysPkg::dataT'(ovfQ);
            `TMR_EN:    apb.prdata = ahbApbSysPkg::dataT'(enQ);
            default:    apb.prdata = '0;
        endcase
    end

    assign apb.pready = 1'b1;
    assign irq_o      = ovfQ;

endmodule

//--- sim/ahbApbSysTb.sv
`timescale 1ns/1ns
`include "ahbApbSys_consts.svh"

module ahbApbSysTb;

    localparam int TIMEOUT = 200;

    logic               HCLK;
    logic               HRESETn;
    ahbApbSysPkg::addrT hAddr;
    logic [1:0]         hTrans;
    logic               hWrite;
    ahbApbSysPkg::dataT hWdata;
    logic               hSel;
    logic               hReady;
    ahbApbSysPkg::dataT hRdata;
    logic               hReadyOut;
    logic [1:0]         irq;
    logic [1:0]         pwm;

    int                 checks;
    int                 errors;
    int                 timeouts;
    integer             seed;
    ahbApbSysPkg::addrT regAddrs[10];
    ahbApbSysPkg::dataT regVals[10];

    ahbApbSys dut0 (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hAddr_i     (hAddr),
        .hTrans_i    (hTrans),
        .hWrite_i    (hWrite),
        .hWdata_i    (hWdata),
        .hSel_i      (hSel),
        .hReady_i    (hReady),
        .hRdata_o    (hRdata),
        .hReadyOut_o (hReadyOut),
        .irq_o       (irq),
        .pwm_o       (pwm)
    );

    always #2 HCLK = ~HCLK;

    function automatic ahbApbSysPkg::addrT regAddr(input logic [3:0] slot, input logic [2:0] idx);
        ahbApbSysPkg::addrT a;
        a = '0;
        a[`SLOT_MSB:`SLOT_LSB] = slot;
        a[`REG_MSB:`REG_LSB] = idx;
        return a;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // Counts low cycles of hReadyOut_o on falling edges
    task automatic waitReady(output int waits);
        int n;
        n = 0;
        while (!hReadyOut && n < TIMEOUT) begin
            n++;
            @(negedge HCLK);
        end
        if (!hReadyOut) begin
            timeouts++;
            $display("Timeout: hReadyOut_o never returned high after a transfer");
        end
        waits = n;
    endtask

    task automatic ahbWrite(input ahbApbSysPkg::addrT addr, input ahbApbSysPkg::dataT data);
        int waits;
        hSel   = 1'b1;
        hTrans = 2'b10;
        hWrite = 1'b1;
        hAddr  = addr;
        @(negedge HCLK);
        hSel   = 1'b0;
        hTrans = 2'b00;
        hWdata = data;
        waitReady(waits);
        checkValue("hReadyOut_o low cycles (write)", waits, 2);
    endtask

    task automatic ahbRead(input ahbApbSysPkg::addrT addr, output ahbApbSysPkg::dataT data);
        int waits;
        hSel   = 1'b1;
        hTrans = 2'b10;
        hWrite = 1'b0;
        hAddr  = addr;
        @(negedge HCLK);
        hSel   = 1'b0;
        hTrans = 2'b00;
        waitReady(waits);
        checkValue("hReadyOut_o low cycles (read)", waits, 2);
        data = hRdata;
    endtask

    task automatic readExpect(input ahbApbSysPkg::addrT addr, input ahbApbSysPkg::dataT exp);
        ahbApbSysPkg::dataT d;
        ahbRead(addr, d);
        checkValue($sformatf("hRdata_o @0x%08h", addr), d, exp);
    endtask

    task automatic resetState();
        checkValue("hReadyOut_o", hReadyOut, 1);
        checkValue("irq_o", irq, 0);
        checkValue("pwm_o", pwm, 0);
        for (int s = 0; s < 2; s++) begin
            readExpect(regAddr(s, `TMR_COUNT), 0);
        end
        for (int s = 2; s < 4; s++) begin
            for (int r = 0; r < 4; r++) begin
                readExpect(regAddr(s, r), 0);
            end
        end
    endtask

    // PRE and CMP of both timers, PRE, PERIOD and DUTY of both PWMs
    task automatic registerReadback();
        for (int s = 0; s < 2; s++) begin
            regAddrs[s*2]   = regAddr(s, `TMR_PRE);
            regAddrs[s*2+1] = regAddr(s, `TMR_CMP);
        end
        for (int s = 2; s < 4; s++) begin
            regAddrs[4+(s-2)*3]   = regAddr(s, `PWM_PRE);
            regAddrs[4+(s-2)*3+1] = regAddr(s, `PWM_PERIOD);
            regAddrs[4+(s-2)*3+2] = regAddr(s, `PWM_DUTY);
        end
        for (int i = 0; i < 10; i++) begin
            regVals[i] = $random(seed);
            ahbWrite(regAddrs[i], regVals[i]);
        end
        for (int i = 0; i < 10; i++) begin
            readExpect(regAddrs[i], regVals[i]);
        end
    endtask

    task automatic unmappedSlot();
        readExpect(regAddr(9, 1), 0);
        for (int r = 0; r < 5; r++) begin
            ahbWrite(regAddr(9, r), $random(seed));
        end
        for (int i = 0; i < 10; i++) begin
            readExpect(regAddrs[i], regVals[i]);
        end
    endtask

    task automatic timerOverflow();
        ahbApbSysPkg::dataT cnt;
        int n;
        ahbWrite(regAddr(`SLOT_TMR1, `TMR_PRE), 1);
        ahbWrite(regAddr(`SLOT_TMR1, `TMR_CMP), 5);
        ahbWrite(regAddr(`SLOT_TMR1, `TMR_EN), 1);
        n = 0;
        while (!irq[1] && n < TIMEOUT) begin
            checkValue("irq_o[0]", irq[0], 0);
            n++;
            @(negedge HCLK);
        end
        if (!irq[1]) begin
            timeouts++;
            $display("Timeout: timer 1 never raised its interrupt");
        end
        checkValue("irq_o[0]", irq[0], 0);
        ahbRead(regAddr(`SLOT_TMR1, `TMR_COUNT), cnt);
        checks++;
        assert (cnt <= 5) else begin
            errors++;
            $display("** Error: TMR_COUNT = 0x%08h, expected at most 0x00000005", cnt);
        end
        ahbWrite(regAddr(`SLOT_TMR1, `TMR_OVF), 1);
        checkValue("irq_o[1]", irq[1], 0);
        ahbWrite(regAddr(`SLOT_TMR1, `TMR_EN), 0);
    endtask

    // Cycles that pwm_o[0] stays at one level
    task automatic measureLevel(input logic level, output int cycles);
        int n;
        n = 0;
        while (pwm[0] === level && n < TIMEOUT) begin
            checkValue("pwm_o[1]", pwm[1], 0);
            n++;
            @(negedge HCLK);
        end
        if (pwm[0] === level) begin
            timeouts++;
            $display("Timeout: pwm_o[0] stuck at %0d", level);
        end
        cycles = n;
    endtask

    task automatic pwmWaveform();
        int high;
        int low;
        int skip;
        ahbWrite(regAddr(`SLOT_PWM0, `PWM_PRE), 1);
        ahbWrite(regAddr(`SLOT_PWM0, `PWM_PERIOD), 9);
        ahbWrite(regAddr(`SLOT_PWM0, `PWM_DUTY), 3);
        ahbWrite(regAddr(`SLOT_PWM0, `PWM_EN), 1);
        // Skip to the first clean rising edge
        measureLevel(1'b1, skip);
        measureLevel(1'b0, skip);
        measureLevel(1'b1, high);
        measureLevel(1'b0, low);
        checkValue("pwm_o[0] high cycles", high, 6);
        checkValue("pwm_o[0] period cycles", high + low, 20);
    endtask

    initial begin
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        seed     = 32'h72e5;
        HCLK     = 1'b0;
        HRESETn  = 1'b0;
        hAddr    = '0;
        hTrans   = 2'b00;
        hWrite   = 1'b0;
        hWdata   = '0;
        hSel     = 1'b0;
        hReady   = 1'b1;
        repeat (16) @(negedge HCLK);
        HRESETn = 1'b1;
        @(negedge HCLK);

        resetState();
        registerReadback();
        unmappedSlot();
        timerOverflow();
        pwmWaveform();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
